// File: compile.f
+incdir+hdl
hdl/tcb_pkg.sv
hdl/tcb_copy_ctrl.sv
hdl/tcb_rsp_register.sv
hdl/tcb_decoder.sv
hdl/tcb_sram.sv
hdl/tcb_copy_top.sv
tb/tcb_copy_tb.sv

// File: tb/tcb_copy_tb.sv
// TCB copy subsystem testbench with a reference memory model and per read checks
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_copy_tb
  import tcb_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int WORDS   = 2 * `TCB_BANK_DEPTH;

  // read response still owed, and the cycle it must appear
  typedef struct packed
  {
    logic [31:0]           due;
    logic [`TCB_ADR_W-1:0] adr;
    logic [`TCB_DAT_W-1:0] exp;
  } rd_exp_t;

  logic                  man;
  logic                  rst_n;
  logic                  start;
  copy_cfg_t             cfg;
  logic                  ext_vld;
  tcb_req_t              ext_req;
  logic                  ext_rdy;
  logic [`TCB_DAT_W-1:0] ext_rdt;
  logic                  busy;
  logic                  done;

  // both banks, indexed by the full address
  logic [`TCB_DAT_W-1:0] ref_mem [0:WORDS-1];
  rd_exp_t               rd_q [$];
  logic [31:0]           seed;
  logic [31:0]           cyc;
  logic [31:0]           done_cyc;
  int                    checks;
  int                    errors;
  int                    done_cnt;
  string                 cur_test;

  tcb_copy_top uut (
    .man     (man),
    .rst_n   (rst_n),
    .start   (start),
    .cfg     (cfg),
    .ext_vld (ext_vld),
    .ext_req (ext_req),
    .ext_rdy (ext_rdy),
    .ext_rdt (ext_rdt),
    .busy    (busy),
    .done    (done)
  );

  initial
  begin
    man = 1'b0;
    forever #2 man = ~man;
  end

  // free running cycle count, read only at falling edges
  always @(posedge man)
    cyc <= cyc + 32'd1;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // enabled bytes pass, others read as zero
  function automatic logic [31:0] mask_bytes(logic [31:0] dat, logic [3:0] byt);
    logic [31:0] res;
    for (int i = 0; i < 4; i++)
      res[i*8 +: 8] = byt[i] ? dat[i*8 +: 8] : 8'h00;
    return res;
  endfunction

  // write only touches enabled bytes
  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] dat,
                                              logic [3:0] byt);
    logic [31:0] res;
    for (int i = 0; i < 4; i++)
      res[i*8 +: 8] = byt[i] ? dat[i*8 +: 8] : old[i*8 +: 8];
    return res;
  endfunction

  function automatic tcb_req_t make_req(tcb_op_t op, logic [7:0] adr, logic [3:0] byt,
                                        logic [31:0] wdt);
    tcb_req_t req;
    req.op  = op;
    req.adr = adr;
    req.byt = byt;
    req.wdt = wdt;
    return req;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  ////////////////////
  // monitor
  ////////////////////

  always @(negedge man)
  begin
    rd_exp_t e;
    if (rst_n)
    begin
      // engine owns the bus, external port stalls
      if (busy)
        check_value("ext_rdy while busy", 32'd0, {31'd0, ext_rdy});
      if (done)
      begin
        done_cnt++;
        done_cyc = cyc;
        check_value("busy with done", 32'd0, {31'd0, busy});
      end
      // response due in exactly this cycle
      if ((rd_q.size() > 0) && (rd_q[0].due == cyc))
      begin
        e = rd_q.pop_front();
        check_value($sformatf("read 0x%02h", e.adr), e.exp, ext_rdt);
      end
    end
  end

  ////////////////////
  // bus access
  ////////////////////

  // hold one request until the port takes it, returns on the transfer edge
  task automatic issue(input tcb_req_t req, output logic [31:0] acc);
    int      wait_cnt;
    rd_exp_t e;
    wait_cnt = 0;
    acc      = '0;
    ext_vld <= 1'b1;
    ext_req <= req;
    do
    begin
      @(negedge man);
      wait_cnt++;
    end
    while (!ext_rdy && (wait_cnt < TIMEOUT));
    if (!ext_rdy)
    begin
      errors++;
      $display("Timeout: external port never became ready in %s", cur_test);
    end
    else
    begin
      acc = cyc;
      if (req.op == OP_READ)
      begin
        // data follows the accepting cycle by the bus latency
        e.due = cyc + `TCB_RSP_DLY;
        e.adr = req.adr;
        e.exp = mask_bytes(ref_mem[req.adr], req.byt);
        rd_q.push_back(e);
      end
      else
        ref_mem[req.adr] = merge_bytes(ref_mem[req.adr], req.wdt, req.byt);
    end
    @(posedge man);
  endtask

  task automatic drain_reads();
    int wait_cnt;
    wait_cnt = 0;
    while ((rd_q.size() > 0) && (wait_cnt < TIMEOUT))
    begin
      @(posedge man);
      wait_cnt++;
    end
    if (rd_q.size() > 0)
    begin
      errors++;
      $display("Timeout: %0d read responses never checked in %s", rd_q.size(), cur_test);
      rd_q.delete();
    end
  endtask

  // back to back full word reads
  task automatic read_range(input logic [7:0] lo, input int n);
    logic [31:0] acc;
    for (int i = 0; i < n; i++)
      issue(make_req(OP_READ, 8'(lo + i), 4'hf, '0), acc);
    ext_vld <= 1'b0;
    drain_reads();
  endtask

  ////////////////////
  // copy engine
  ////////////////////

  task automatic run_copy(input copy_cfg_t c);
    logic [31:0] s;
    logic        prev_busy;
    int          wait_cnt;
    int          d0;
    d0 = done_cnt;
    start <= 1'b1;
    cfg   <= c;
    @(negedge man);
    s = cyc;
    @(posedge man);
    start <= 1'b0;
    // destination takes the source words
    for (int i = 0; i < c.len; i++)
      ref_mem[8'(c.dst + i)] = ref_mem[8'(c.src + i)];
    wait_cnt  = 0;
    prev_busy = 1'b0;
    @(negedge man);
    while (!done && (wait_cnt < TIMEOUT))
    begin
      prev_busy = busy;
      @(negedge man);
      wait_cnt++;
    end
    if (!done)
    begin
      errors++;
      $display("Timeout: copy engine never raised done in %s", cur_test);
    end
    else
    begin
      // four cycles per word plus one
      check_value("done cycle", s + 32'd4 * c.len + 32'd1, cyc);
      check_value("busy before done", {31'd0, c.len != 8'd0}, {31'd0, prev_busy});
    end
    repeat (4) @(posedge man);
    check_value("done pulses", d0 + 1, done_cnt);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] acc;
    logic [7:0]  part_adr [0:23];
    copy_cfg_t   c;
    copy_cfg_t   c2;
    int          d0;
    seed     = 32'ha124de6f;
    cyc      = '0;
    done_cyc = '0;
    checks   = 0;
    errors   = 0;
    done_cnt = 0;
    rst_n    = 1'b0;
    start    = 1'b0;
    cfg      = '0;
    ext_vld  = 1'b0;
    ext_req  = '0;
    repeat (8) @(posedge man);
    rst_n <= 1'b1;

    // idle outputs out of reset
    cur_test = "reset";
    @(negedge man);
    check_value("busy", 32'd0, {31'd0, busy});
    check_value("done", 32'd0, {31'd0, done});
    check_value("ext_rdt", 32'd0, ext_rdt);
    check_value("ext_rdy", 32'd1, {31'd0, ext_rdy});
    @(posedge man);

    // fill both banks, then stream every word back
    cur_test = "full_rw";
    for (int a = 0; a < WORDS; a++)
      issue(make_req(OP_WRITE, 8'(a), 4'hf, rand_word()), acc);
    for (int a = 0; a < WORDS; a++)
      issue(make_req(OP_READ, 8'(a), 4'hf, '0), acc);
    ext_vld <= 1'b0;
    drain_reads();

    // random byte enables on writes and reads
    cur_test = "partial";
    for (int k = 0; k < 24; k++)
    begin
      r = rand_word();
      part_adr[k] = r[31:24];
      issue(make_req(OP_WRITE, r[31:24], r[23:20], rand_word()), acc);
    end
    for (int k = 0; k < 24; k++)
    begin
      r = rand_word();
      issue(make_req(OP_READ, part_adr[k], r[27:24], rand_word()), acc);
    end
    ext_vld <= 1'b0;
    drain_reads();

    // bank 0 block into bank 1, neighbours untouched
    cur_test = "copy";
    c.src = 8'h10;
    c.dst = 8'ha0;
    c.len = 8'd12;
    run_copy(c);
    read_range(8'h9e, 16);
    read_range(8'h10, 12);

    // external read waits out a copy, second start dropped
    cur_test = "held";
    c.src  = 8'h40;
    c.dst  = 8'hc0;
    c.len  = 8'd6;
    c2.src = 8'h00;
    c2.dst = 8'he0;
    c2.len = 8'd4;
    d0     = done_cnt;
    start <= 1'b1;
    cfg   <= c;
    @(negedge man);
    s = cyc;
    @(posedge man);
    start <= 1'b0;
    for (int i = 0; i < c.len; i++)
      ref_mem[8'(c.dst + i)] = ref_mem[8'(c.src + i)];
    @(posedge man);
    start <= 1'b1;
    cfg   <= c2;
    @(posedge man);
    start <= 1'b0;
    issue(make_req(OP_READ, 8'hc2, 4'hf, '0), acc);
    ext_vld <= 1'b0;
    check_value("held read accept cycle", s + 32'd4 * c.len + 32'd1, acc);
    check_value("accept on done", done_cyc, acc);
    drain_reads();
    repeat (4 * c2.len + 4) @(posedge man);
    check_value("done pulses", d0 + 1, done_cnt);
    check_value("busy after copy", 32'd0, {31'd0, busy});
    read_range(8'hbe, 10);
    read_range(8'he0, 4);

    // empty block finishes at once
    cur_test = "empty_copy";
    c.src = 8'h05;
    c.dst = 8'h85;
    c.len = 8'd0;
    run_copy(c);
    read_range(8'h80, 16);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: hdl/tcb_copy_top.sv
// TCB copy subsystem top with engine, response slice, decoder and two banks
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_copy_top
  import tcb_pkg::*;
(
  input  logic                  man,
  input  logic                  rst_n,
  // copy control
  input  logic                  start,
  input  copy_cfg_t             cfg,
  // external manager
  input  logic                  ext_vld,
  input  tcb_req_t              ext_req,
  output logic                  ext_rdy,
  output logic [`TCB_DAT_W-1:0] ext_rdt,
  // status
  output logic                  busy,
  output logic                  done
);

  // control to slice
  logic                  ctl_vld;
  tcb_req_t              ctl_req;
  logic                  ctl_rdy;
  // slice to decoder
  logic                  dec_vld;
  tcb_req_t              dec_req;
  logic                  dec_rdy;
  logic [`TCB_DAT_W-1:0] dec_rdt;
  // decoder to banks
  logic [1:0]            mem_vld;
  tcb_req_t              mem_req;
  logic [1:0]            mem_rdy;
  logic [`TCB_DAT_W-1:0] mem_rdt0;
  logic [`TCB_DAT_W-1:0] mem_rdt1;

  ////////////////////
  // manager side
  ////////////////////

  // shared response word feeds both engine and external port
  tcb_copy_ctrl u_ctrl (
    .man     (man),
    .rst_n   (rst_n),
    .start   (start),
    .cfg     (cfg),
    .ext_vld (ext_vld),
    .ext_req (ext_req),
    .ext_rdy (ext_rdy),
    .bus_vld (ctl_vld),
    .bus_req (ctl_req),
    .bus_rdy (ctl_rdy),
    .bus_rdt (ext_rdt),
    .busy    (busy),
    .done    (done)
  );

  tcb_rsp_register u_rsp (
    .man     (man),
    .rst_n   (rst_n),
    .sub_vld (ctl_vld),
    .sub_req (ctl_req),
    .sub_rdy (ctl_rdy),
    .sub_rdt (ext_rdt),
    .man_vld (dec_vld),
    .man_req (dec_req),
    .man_rdy (dec_rdy),
    .man_rdt (dec_rdt)
  );

  ////////////////////
  // memory side
  ////////////////////

  tcb_decoder u_dec (
    .man      (man),
    .rst_n    (rst_n),
    .sub_vld  (dec_vld),
    .sub_req  (dec_req),
    .sub_rdy  (dec_rdy),
    .sub_rdt  (dec_rdt),
    .mem_vld  (mem_vld),
    .mem_req  (mem_req),
    .mem_rdy  (mem_rdy),
    .mem_rdt0 (mem_rdt0),
    .mem_rdt1 (mem_rdt1)
  );

  // bank 0, lower half of the address space
  tcb_sram u_bank0 (
    .man (man),
    .vld (mem_vld[0]),
    .req (mem_req),
    .rdy (mem_rdy[0]),
    .rdt (mem_rdt0)
  );

  tcb_sram u_bank1 (
    .man (man),
    .vld (mem_vld[1]),
    .req (mem_req),
    .rdy (mem_rdy[1]),
    .rdt (mem_rdt1)
  );

endmodule

// File: hdl/tcb_sram.sv
// TCB synchronous memory bank with byte enabled writes and registered reads
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_sram
  import tcb_pkg::*;
(
  input  logic                  man,
  // request
  input  logic                  vld,
  input  tcb_req_t              req,
  output logic                  rdy,
  // read data, one cycle after the read
  output logic [`TCB_DAT_W-1:0] rdt
);

  localparam int BYT_SZ = `TCB_DAT_W / `TCB_BYT_W;
  localparam int IDX_W  = $clog2(`TCB_BANK_DEPTH);

  // byte addressable storage
  logic [`TCB_BYT_W-1:0][BYT_SZ-1:0] mem [0:`TCB_BANK_DEPTH-1];

  // local word index, decoder already cleared the bank bit
  logic [IDX_W-1:0] idx;
  logic             wen;
  logic             ren;

  assign idx = req.adr[IDX_W-1:0];
  assign wen = vld && (req.op == OP_WRITE);
  assign ren = vld && (req.op == OP_READ);

  // never stalls
  assign rdy = 1'b1;

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge man)
  begin
    if (wen)
    begin
      // untouched bytes keep their old value
      for (int i = 0; i < `TCB_BYT_W; i++)
        if (req.byt[i])
          mem[idx][i] <= req.wdt[i*BYT_SZ +: BYT_SZ];
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // full word, masking happens in the slice
  always_ff @(posedge man)
  begin
    if (ren)
      rdt <= mem[idx];
  end

endmodule

// File: hdl/tcb_decoder.sv
// TCB two bank address decoder with delayed response select
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_decoder
  import tcb_pkg::*;
(
  input  logic                  man,
  input  logic                  rst_n,
  // upstream port
  input  logic                  sub_vld,
  input  tcb_req_t              sub_req,
  output logic                  sub_rdy,
  output logic [`TCB_DAT_W-1:0] sub_rdt,
  // bank ports, request shared
  output logic [1:0]            mem_vld,
  output tcb_req_t              mem_req,
  input  logic [1:0]            mem_rdy,
  input  logic [`TCB_DAT_W-1:0] mem_rdt0,
  input  logic [`TCB_DAT_W-1:0] mem_rdt1
);

  // bank select from address msb
  logic sel;
  // select aligned to returning bank data
  logic sel_q [0:`TCB_MEM_DLY-1];

  assign sel = sub_req.adr[`TCB_ADR_W-1];

  ////////////////////
  // request steering
  ////////////////////

  assign mem_vld[0] = sub_vld && !sel;
  assign mem_vld[1] = sub_vld && sel;

  // banks only see their local address
  always_comb
  begin
    mem_req = sub_req;
    mem_req.adr[`TCB_ADR_W-1] = 1'b0;
  end

  assign sub_rdy = mem_rdy[sel];

  ////////////////////
  // response select
  ////////////////////

  always_ff @(posedge man)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `TCB_MEM_DLY; i++)
        sel_q[i] <= 1'b0;
    end
    else
    begin
      sel_q[0] <= sel;
      for (int i = 1; i < `TCB_MEM_DLY; i++)
        sel_q[i] <= sel_q[i-1];
    end
  end

  // slice ignores this unless a read tag arrives
  assign sub_rdt = sel_q[`TCB_MEM_DLY-1] ? mem_rdt1 : mem_rdt0;

endmodule

// File: hdl/tcb_rsp_register.sv
// TCB response path register slice with per byte read data masking
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_rsp_register
  import tcb_pkg::*;
(
  input  logic                  man,
  input  logic                  rst_n,
  // subordinate side, manager connects here
  input  logic                  sub_vld,
  input  tcb_req_t              sub_req,
  output logic                  sub_rdy,
  output logic [`TCB_DAT_W-1:0] sub_rdt,
  // manager side, subordinate connects here
  output logic                  man_vld,
  output tcb_req_t              man_req,
  input  logic                  man_rdy,
  input  logic [`TCB_DAT_W-1:0] man_rdt
);

  localparam int BYT_SZ = `TCB_DAT_W / `TCB_BYT_W;

  // read tag following each request through the bank latency
  typedef struct packed
  {
    logic                  ren;
    logic [`TCB_BYT_W-1:0] byt;
  } rsp_tag_t;

  rsp_tag_t tag_q [0:`TCB_MEM_DLY-1];

  // request side is combinational
  assign man_vld = sub_vld;
  assign man_req = sub_req;
  assign sub_rdy = man_rdy;

  ////////////////////
  // tag pipeline
  ////////////////////

  always_ff @(posedge man)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `TCB_MEM_DLY; i++)
        tag_q[i] <= '0;
    end
    else
    begin
      // only accepted reads carry a live tag
      tag_q[0].ren <= sub_vld && man_rdy && (sub_req.op == OP_READ);
      tag_q[0].byt <= sub_req.byt;
      for (int i = 1; i < `TCB_MEM_DLY; i++)
        tag_q[i] <= tag_q[i-1];
    end
  end

  // masked response, held between reads
  always_ff @(posedge man)
  begin
    if (!rst_n)
      sub_rdt <= '0;
    else if (tag_q[`TCB_MEM_DLY-1].ren)
    begin
      for (int i = 0; i < `TCB_BYT_W; i++)
        sub_rdt[i*BYT_SZ +: BYT_SZ] <= tag_q[`TCB_MEM_DLY-1].byt[i] ?
                                       man_rdt[i*BYT_SZ +: BYT_SZ] : '0;
    end
  end

endmodule

// File: hdl/tcb_copy_ctrl.sv
// TCB copy engine FSM with arbitration between external manager and engine
`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_copy_ctrl
  import tcb_pkg::*;
(
  input  logic                  man,
  input  logic                  rst_n,
  // copy control
  input  logic                  start,
  input  copy_cfg_t             cfg,
  // external manager port
  input  logic                  ext_vld,
  input  tcb_req_t              ext_req,
  output logic                  ext_rdy,
  // bus toward the response slice
  output logic                  bus_vld,
  output tcb_req_t              bus_req,
  input  logic                  bus_rdy,
  input  logic [`TCB_DAT_W-1:0] bus_rdt,
  // status
  output logic                  busy,
  output logic                  done
);

  // wait counter spans the full response latency
  localparam int CNT_W = $clog2(`TCB_RSP_DLY + 1);

  copy_state_t           state;
  copy_cfg_t             cfg_q;
  logic [7:0]            idx;
  logic [CNT_W-1:0]      cnt;
  logic                  rsp_hit;
  logic                  last;
  logic [`TCB_DAT_W-1:0] dat_q;
  logic                  eng_vld;
  tcb_req_t              eng_req;

  ////////////////////
  // FSM
  ////////////////////

  // read data lands on the last wait cycle
  assign rsp_hit = (cnt == CNT_W'(`TCB_RSP_DLY - 1));
  // final word of the block
  assign last    = (idx == cfg_q.len - 8'd1);

  always_ff @(posedge man)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      idx   <= '0;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          idx <= '0;
          // empty block skips straight to done
          if (start && (cfg.len == 8'd0))
            state <= ST_DONE;
          else if (start)
            state <= ST_READ;
        end
        ST_READ:
        begin
          cnt <= '0;
          if (bus_rdy)
            state <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (rsp_hit)
            state <= ST_WRITE;
          else
            cnt <= cnt + 1'b1;
        end
        ST_WRITE:
        begin
          if (bus_rdy && last)
            state <= ST_DONE;
          else if (bus_rdy)
          begin
            idx   <= idx + 8'd1;
            state <= ST_READ;
          end
        end
        // one cycle pulse, then back to idle
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // setup and word buffer
  always_ff @(posedge man)
  begin
    if ((state == ST_IDLE) && start)
      cfg_q <= cfg;
    if ((state == ST_WAIT) && rsp_hit)
      dat_q <= bus_rdt;
  end

  ////////////////////
  // engine request
  ////////////////////

  assign eng_vld = (state == ST_READ) || (state == ST_WRITE);

  always_comb
  begin
    // full word transfers only
    eng_req.byt = '1;
    eng_req.wdt = dat_q;
    if (state == ST_WRITE)
    begin
      eng_req.op  = OP_WRITE;
      eng_req.adr = cfg_q.dst + idx;
    end
    else
    begin
      eng_req.op  = OP_READ;
      eng_req.adr = cfg_q.src + idx;
    end
  end

  ////////////////////
  // port arbitration
  ////////////////////

  // done state already frees the bus
  assign busy    = (state == ST_READ) || (state == ST_WAIT) || (state == ST_WRITE);
  assign done    = (state == ST_DONE);

  // external manager stalls while engine owns the bus
  assign bus_vld = busy ? eng_vld : ext_vld;
  assign bus_req = busy ? eng_req : ext_req;
  assign ext_rdy = busy ? 1'b0 : bus_rdy;

endmodule

// File: hdl/tcb_pkg.sv
// TCB copy subsystem shared types for requests, copy setup and control states
`include "tcb_macros.svh"

package tcb_pkg;

  ////////////////////
  // bus request
  ////////////////////

  // request direction
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } tcb_op_t;

  // request payload, 45 bits
  typedef struct packed
  {
    // read or write
    tcb_op_t               op;
    // word address
    logic [`TCB_ADR_W-1:0] adr;
    // byte enables, used by reads too
    logic [`TCB_BYT_W-1:0] byt;
    // write data
    logic [`TCB_DAT_W-1:0] wdt;
  } tcb_req_t;

  ////////////////////
  // copy engine
  ////////////////////

  // block copy setup, sampled at start
  typedef struct packed
  {
    logic [`TCB_ADR_W-1:0] src;
    logic [`TCB_ADR_W-1:0] dst;
    // word count, zero is a no-op copy
    logic [7:0]            len;
  } copy_cfg_t;

  // engine states
  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_WRITE,
    ST_DONE
  } copy_state_t;

endpackage

// File: hdl/tcb_macros.svh
// TCB copy subsystem bus widths, bank depth and latency macros
`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

////////////////////
// bus geometry
////////////////////

// word address, top bit selects the bank
`define TCB_ADR_W 8
// data word width
`define TCB_DAT_W 32
// one enable per byte
`define TCB_BYT_W 4

////////////////////
// memory and latency
////////////////////

// words in each bank
`define TCB_BANK_DEPTH 128
// bank read latency in cycles
`define TCB_MEM_DLY 1
// latency seen by a manager, bank plus response slice
`define TCB_RSP_DLY (`TCB_MEM_DLY + 1)

`endif
